// ==== Makefile ====
# Verilator build and run for the AXI slave link concatenator

VERILATOR ?= verilator
TOP       ?= tb_axi_mm_slave_concat
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+verilog
verilog/concat_pkg.sv
verilog/tx_rr_arbiter.sv
verilog/tx_packetizer.sv
verilog/phy_tx_framer.sv
verilog/phy_rx_deframer.sv
verilog/rx_packet_demux.sv
verilog/axi_mm_slave_concat.sv
verification/concat_assert.sv
verification/tb_axi_mm_slave_concat.sv

// ==== verification/concat_assert.sv ====
// Link concatenator protocol checks: one receive push at a time and transmit valid/ready rules
module concat_assert (
  input logic                clk_rd,
  input logic                rst_rd_n,
  input logic                ar_push,
  input logic                aw_push,
  input logic                w_push,
  input logic                r_valid,
  input logic                r_ready,
  input concat_pkg::r_data_t r_data,
  input logic                b_valid,
  input logic                b_ready,
  input concat_pkg::b_data_t b_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // Channel code selects a single target
  a_one_push: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    $onehot0({ar_push, aw_push, w_push}))
    else $error("More than one receive push is high");

  a_ready_excl: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !(b_ready && r_ready))
    else $error("b_ready and r_ready are high together");

  // Stalled beats hold valid and data
  a_r_hold: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_data)))
    else $error("Stalled read-data beat dropped valid or changed data");

  a_b_hold: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    (b_valid && !b_ready) |=> (b_valid && $stable(b_data)))
    else $error("Stalled write-response beat dropped valid or changed data");

endmodule

bind axi_mm_slave_concat concat_assert i_concat_assert (
  .clk_rd   (clk_rd),
  .rst_rd_n (rst_rd_n),
  .ar_push  (ar_push),
  .aw_push  (aw_push),
  .w_push   (w_push),
  .r_valid  (r_valid),
  .r_ready  (r_ready),
  .r_data   (r_data),
  .b_valid  (b_valid),
  .b_ready  (b_ready),
  .b_data   (b_data)
);

// ==== verification/tb_axi_mm_slave_concat.sv ====
// Testbench for the AXI slave link concatenator: seeded random traffic checked against a cycle model
`include "concat_macros.svh"

module tb_axi_mm_slave_concat;

  timeunit 1ns;
  timeprecision 1ps;

  import concat_pkg::*;

  localparam int RESET_CYCLES   = 8;
  localparam int RANDOM_CYCLES  = 2000;
  // Reset and random phases with a small margin on top
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + 92;

  logic      clk_rd;
  logic      rst_rd_n;
  logic      r_valid;
  logic      r_ready;
  r_data_t   r_data;
  logic      b_valid;
  logic      b_ready;
  b_data_t   b_data;
  logic      ar_push;
  ar_data_t  ar_data;
  logic      aw_push;
  aw_data_t  aw_data;
  logic      w_push;
  w_data_t   w_data;
  logic      ar_credit;
  logic      aw_credit;
  logic      w_credit;
  logic      marker;
  logic      r_credit;
  logic      b_credit;
  phy_word_t tx_phy;
  phy_word_t rx_phy;

  // Model state
  logic      last_is_r;
  logic      exp_r_ready;
  logic      exp_b_ready;
  logic      r_taken;
  logic      b_taken;
  phy_word_t exp_tx_word;
  phy_word_t rx_prev;

  integer      seed = 66;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  logic [31:0] rnd_a;
  logic [31:0] rnd_b;
  logic [31:0] rnd_c;
  logic [31:0] rnd_d;

  axi_mm_slave_concat i_axi_mm_slave_concat (
    .clk_rd    (clk_rd),
    .rst_rd_n  (rst_rd_n),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r_data    (r_data),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_data    (b_data),
    .ar_push   (ar_push),
    .ar_data   (ar_data),
    .aw_push   (aw_push),
    .aw_data   (aw_data),
    .w_push    (w_push),
    .w_data    (w_data),
    .ar_credit (ar_credit),
    .aw_credit (aw_credit),
    .w_credit  (w_credit),
    .marker    (marker),
    .r_credit  (r_credit),
    .b_credit  (b_credit),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy)
  );

  initial
  begin
    clk_rd = 1'b0;
    forever
    begin
      #20 clk_rd = ~clk_rd;
    end
  end

  always @(posedge clk_rd)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Compare helpers
  //////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input phy_word_t exp, input phy_word_t act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reset_outputs();
    check_word("reset tx_phy", '0, tx_phy);
    check_bit("reset ar_push", 1'b0, ar_push);
    check_bit("reset aw_push", 1'b0, aw_push);
    check_bit("reset w_push", 1'b0, w_push);
    check_bit("reset r_credit", 1'b0, r_credit);
    check_bit("reset b_credit", 1'b0, b_credit);
  endtask

  //////////////////////////////
  // Cycle model
  //////////////////////////////

  task automatic run_model_checks();
    packet_t   pkt;
    logic [1:0] code;
    phy_word_t next_word;

    // Round robin: tie goes to the channel not served last
    exp_r_ready = r_valid && (!b_valid || !last_is_r);
    exp_b_ready = b_valid && !exp_r_ready;
    check_bit("arbitration r_ready", exp_r_ready, r_ready);
    check_bit("arbitration b_ready", exp_b_ready, b_ready);
    if (r_valid || b_valid)
    begin
      last_is_r = exp_r_ready;
    end
    r_taken = exp_r_ready;
    b_taken = exp_b_ready;

    // Word built in the previous cycle
    check_word("transmit word", exp_tx_word, tx_phy);
    next_word = '0;
    if (exp_r_ready)
    begin
      next_word[0]                         = 1'b1;
      next_word[`TX_PKT_LSB +: `R_W]       = r_data;
      next_word[`TX_PKT_LSB + `R_W]        = 1'b1;
    end
    else if (exp_b_ready)
    begin
      next_word[`TX_PKT_LSB +: `B_W]       = b_data;
      next_word[`TX_PKT_LSB + `B_W]        = 1'b1;
    end
    next_word[`TX_CRD_LSB]     = ar_credit;
    next_word[`TX_CRD_LSB + 1] = aw_credit;
    next_word[`TX_CRD_LSB + 2] = w_credit;
    next_word[`TX_MRK_POS]     = marker;
    exp_tx_word = next_word;

    // Receive outputs follow the word seen one cycle earlier
    code = rx_prev[1:0];
    pkt  = rx_prev[`RX_PKT_LSB +: `PKT_W];
    check_bit("receive ar_push", (code == 2'd0) && pkt[`AR_W], ar_push);
    check_bit("receive aw_push", (code == 2'd1) && pkt[`AW_W], aw_push);
    check_bit("receive w_push", (code == 2'd2) && pkt[`W_W], w_push);
    check_word("receive ar_data", {{(`PHY_W - `AR_W){1'b0}}, pkt[0 +: `AR_W]},
               {{(`PHY_W - `AR_W){1'b0}}, ar_data});
    check_word("receive aw_data", {{(`PHY_W - `AW_W){1'b0}}, pkt[0 +: `AW_W]},
               {{(`PHY_W - `AW_W){1'b0}}, aw_data});
    check_word("receive w_data", {{(`PHY_W - `W_W){1'b0}}, pkt[0 +: `W_W]},
               {{(`PHY_W - `W_W){1'b0}}, w_data});
    check_bit("receive r_credit", rx_prev[`RX_R_CRD_POS], r_credit);
    check_bit("receive b_credit", rx_prev[`RX_B_CRD_POS], b_credit);
    rx_prev = rx_phy;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    rst_rd_n  <= 1'b0;
    r_valid   <= 1'b0;
    r_data    <= '0;
    b_valid   <= 1'b0;
    b_data    <= '0;
    ar_credit <= 1'b0;
    aw_credit <= 1'b0;
    w_credit  <= 1'b0;
    marker    <= 1'b0;
    rx_phy    <= '0;
    last_is_r   = 1'b1;
    r_taken     = 1'b0;
    b_taken     = 1'b0;
    exp_tx_word = '0;
    rx_prev     = '0;

    for (int cyc = 0; cyc < RESET_CYCLES + RANDOM_CYCLES; cyc++)
    begin
      @(posedge clk_rd);
      if (cyc == RESET_CYCLES)
      begin
        rst_rd_n <= 1'b1;
      end
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      rnd_c = $random(seed);
      rnd_d = $random(seed);
      ar_credit <= rnd_a[8];
      aw_credit <= rnd_a[9];
      w_credit  <= rnd_a[10];
      marker    <= rnd_a[11];
      rx_phy    <= {rnd_a[31:16], rnd_b, rnd_c};
      // Beats start after reset, a losing beat stays put
      if (cyc >= RESET_CYCLES && (!r_valid || r_taken))
      begin
        r_valid <= (rnd_a[1:0] != 2'b00);
        r_data  <= {rnd_a[14:12], rnd_d[1:0], rnd_c};
      end
      if (cyc >= RESET_CYCLES && (!b_valid || b_taken))
      begin
        b_valid <= (rnd_a[3:2] != 2'b00);
        b_data  <= rnd_d[7:4];
      end

      @(negedge clk_rd);
      if (cyc <= RESET_CYCLES)
      begin
        check_reset_outputs();
      end
      if (cyc >= RESET_CYCLES)
      begin
        run_model_checks();
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/axi_mm_slave_concat.sv ====
// AXI memory-mapped slave link concatenator: R/B transmit packing and AR/AW/W receive split
`include "concat_macros.svh"

module axi_mm_slave_concat (
  input  logic                   clk_rd,
  input  logic                   rst_rd_n,

  // Read data toward the link
  input  logic                   r_valid,
  output logic                   r_ready,
  input  concat_pkg::r_data_t    r_data,

  // Write response toward the link
  input  logic                   b_valid,
  output logic                   b_ready,
  input  concat_pkg::b_data_t    b_data,

  // Read address from the link
  output logic                   ar_push,
  output concat_pkg::ar_data_t   ar_data,

  // Write address from the link
  output logic                   aw_push,
  output concat_pkg::aw_data_t   aw_data,

  // Write data from the link
  output logic                   w_push,
  output concat_pkg::w_data_t    w_data,

  // Credits and marker
  input  logic                   ar_credit,
  input  logic                   aw_credit,
  input  logic                   w_credit,
  input  logic                   marker,
  output logic                   r_credit,
  output logic                   b_credit,

  // PHY words
  output concat_pkg::phy_word_t  tx_phy,
  input  concat_pkg::phy_word_t  rx_phy
);

  import concat_pkg::*;

  packet_t  tx_packet;
  tx_chan_e tx_chan;
  rx_chan_e rx_chan;
  packet_t  rx_packet;

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  tx_packetizer i_tx_packetizer (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .b_valid  (b_valid),
    .r_valid  (r_valid),
    .b_data   (b_data),
    .r_data   (r_data),
    .b_ready  (b_ready),
    .r_ready  (r_ready),
    .packet   (tx_packet),
    .chan     (tx_chan)
  );

  phy_tx_framer #(
    .reg_phy (`TX_REG_PHY)
  ) i_phy_tx_framer (
    .clk_rd    (clk_rd),
    .rst_rd_n  (rst_rd_n),
    .chan      (tx_chan),
    .packet    (tx_packet),
    .ar_credit (ar_credit),
    .aw_credit (aw_credit),
    .w_credit  (w_credit),
    .marker    (marker),
    .tx_phy    (tx_phy)
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////

  phy_rx_deframer #(
    .reg_phy (`RX_REG_PHY)
  ) i_phy_rx_deframer (
    .clk_rd    (clk_rd),
    .rst_rd_n  (rst_rd_n),
    .rx_phy    (rx_phy),
    .rx_chan   (rx_chan),
    .rx_packet (rx_packet),
    .r_credit  (r_credit),
    .b_credit  (b_credit)
  );

  // No back-pressure here, the far end sends against credits
  rx_packet_demux i_rx_packet_demux (
    .rx_chan   (rx_chan),
    .rx_packet (rx_packet),
    .ar_push   (ar_push),
    .aw_push   (aw_push),
    .w_push    (w_push),
    .ar_data   (ar_data),
    .aw_data   (aw_data),
    .w_data    (w_data)
  );

endmodule

// ==== verilog/concat_macros.svh ====
// Link concatenator field widths, PHY word bit positions and boundary register enables
`ifndef CONCAT_MACROS_SVH
`define CONCAT_MACROS_SVH

// Word and packet widths
`define PHY_W 80
`define PKT_W 75

// Logic link payload widths
`define AR_W 47
`define AW_W 47
`define W_W 39
`define R_W 37
`define B_W 4

// Transmit word layout, channel bit sits at 0
`define TX_PKT_LSB 1
`define TX_CRD_LSB 76
`define TX_MRK_POS 79

// Receive word layout, channel code sits at 1:0
`define RX_PKT_LSB 2
`define RX_R_CRD_POS 77
`define RX_B_CRD_POS 79

// Boundary flops on the PHY side
`define TX_REG_PHY 1
`define RX_REG_PHY 1

`endif

// ==== verilog/concat_pkg.sv ====
// Shared types of the AXI slave link concatenator: PHY word, packet, payloads, channel codes
`include "concat_macros.svh"

package concat_pkg;

  ////////////////////////////////
  // Word and packet
  ////////////////////////////////

  typedef logic [`PHY_W-1:0] phy_word_t;
  typedef logic [`PKT_W-1:0] packet_t;

  ////////////////////////////////
  // Logic link payloads
  ////////////////////////////////

  // Address channels, received
  typedef logic [`AR_W-1:0] ar_data_t;
  typedef logic [`AW_W-1:0] aw_data_t;

  // Write data, received
  typedef logic [`W_W-1:0] w_data_t;

  // Read data and write response, transmitted
  typedef logic [`R_W-1:0] r_data_t;
  typedef logic [`B_W-1:0] b_data_t;

  ////////////////////////////////
  // Channel codes
  ////////////////////////////////

  // Channel bit of the transmit word
  typedef enum logic [0:0] {
    TX_CHAN_B = 1'b0,
    TX_CHAN_R = 1'b1
  } tx_chan_e;

  // Channel code of the receive word, code 3 carries nothing
  typedef enum logic [1:0] {
    RX_CHAN_AR   = 2'd0,
    RX_CHAN_AW   = 2'd1,
    RX_CHAN_W    = 2'd2,
    RX_CHAN_NONE = 2'd3
  } rx_chan_e;

endpackage

// ==== verilog/phy_rx_deframer.sv ====
// Receive deframer: samples the PHY word and splits out channel code, packet and credits
`include "concat_macros.svh"

module phy_rx_deframer #(
  parameter bit reg_phy = 1'b1
) (
  input  logic                   clk_rd,
  input  logic                   rst_rd_n,
  input  concat_pkg::phy_word_t  rx_phy,
  output concat_pkg::rx_chan_e   rx_chan,
  output concat_pkg::packet_t    rx_packet,
  output logic                   r_credit,
  output logic                   b_credit
);

  import concat_pkg::*;

  phy_word_t rx_word;

  // Optional boundary flop from the PHY
  if (reg_phy)
  begin : g_reg
    phy_word_t rx_q;

    always_ff @(posedge clk_rd or negedge rst_rd_n)
    begin
      if (!rst_rd_n)
      begin
        rx_q <= '0;
      end
      else
      begin
        rx_q <= rx_phy;
      end
    end

    assign rx_word = rx_q;
  end
  else
  begin : g_comb
    assign rx_word = rx_phy;
  end

  // Bit 78 is the far-end marker, not needed here
  assign rx_chan   = rx_chan_e'(rx_word[1:0]);
  assign rx_packet = rx_word[`RX_PKT_LSB +: `PKT_W];
  assign r_credit  = rx_word[`RX_R_CRD_POS];
  assign b_credit  = rx_word[`RX_B_CRD_POS];

endmodule

// ==== verilog/phy_tx_framer.sv ====
// Transmit framer: places channel, packet, credits and marker on the PHY word
`include "concat_macros.svh"

module phy_tx_framer #(
  parameter bit reg_phy = 1'b1
) (
  input  logic                   clk_rd,
  input  logic                   rst_rd_n,
  input  concat_pkg::tx_chan_e   chan,
  input  concat_pkg::packet_t    packet,
  input  logic                   ar_credit,
  input  logic                   aw_credit,
  input  logic                   w_credit,
  input  logic                   marker,
  output concat_pkg::phy_word_t  tx_phy
);

  import concat_pkg::*;

  phy_word_t tx_word;

  // Word layout: channel, packet, AR/AW/W credits, marker on top
  always_comb
  begin
    tx_word                          = '0;
    tx_word[0]                       = chan;
    tx_word[`TX_PKT_LSB +: `PKT_W]   = packet;
    tx_word[`TX_CRD_LSB +: 3]        = {w_credit, aw_credit, ar_credit};
    tx_word[`TX_MRK_POS]             = marker;
  end

  // Optional boundary flop toward the PHY
  if (reg_phy)
  begin : g_reg
    phy_word_t tx_q;

    always_ff @(posedge clk_rd or negedge rst_rd_n)
    begin
      if (!rst_rd_n)
      begin
        tx_q <= '0;
      end
      else
      begin
        tx_q <= tx_word;
      end
    end

    assign tx_phy = tx_q;
  end
  else
  begin : g_comb
    assign tx_phy = tx_word;
  end

endmodule

// ==== verilog/rx_packet_demux.sv ====
// Receive demultiplexer: steers the packet to the AR, AW or W push by channel code
`include "concat_macros.svh"

module rx_packet_demux (
  input  concat_pkg::rx_chan_e  rx_chan,
  input  concat_pkg::packet_t   rx_packet,
  output logic                  ar_push,
  output logic                  aw_push,
  output logic                  w_push,
  output concat_pkg::ar_data_t  ar_data,
  output concat_pkg::aw_data_t  aw_data,
  output concat_pkg::w_data_t   w_data
);

  import concat_pkg::*;

  logic ar_push_bit;
  logic aw_push_bit;
  logic w_push_bit;

  // Push bit sits just above each payload
  assign ar_push_bit = rx_packet[`AR_W];
  assign aw_push_bit = rx_packet[`AW_W];
  assign w_push_bit  = rx_packet[`W_W];

  // Channel code picks the target, code 3 matches none
  assign ar_push = (rx_chan == RX_CHAN_AR) && ar_push_bit;
  assign aw_push = (rx_chan == RX_CHAN_AW) && aw_push_bit;
  assign w_push  = (rx_chan == RX_CHAN_W)  && w_push_bit;

  // Data fans out to all three, push qualifies it
  assign ar_data = rx_packet[0 +: `AR_W];
  assign aw_data = rx_packet[0 +: `AW_W];
  assign w_data  = rx_packet[0 +: `W_W];

endmodule

// ==== verilog/tx_packetizer.sv ====
// Transmit packetizer: arbitrates R and B beats, packs the winner and returns ready
`include "concat_macros.svh"

module tx_packetizer (
  input  logic                 clk_rd,
  input  logic                 rst_rd_n,
  input  logic                 b_valid,
  input  logic                 r_valid,
  input  concat_pkg::b_data_t  b_data,
  input  concat_pkg::r_data_t  r_data,
  output logic                 b_ready,
  output logic                 r_ready,
  output concat_pkg::packet_t  packet,
  output concat_pkg::tx_chan_e chan
);

  import concat_pkg::*;

  logic     grant_valid;
  tx_chan_e grant_chan;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  tx_rr_arbiter i_tx_rr_arbiter (
    .clk_rd      (clk_rd),
    .rst_rd_n    (rst_rd_n),
    .b_req       (b_valid),
    .r_req       (r_valid),
    .grant_valid (grant_valid),
    .grant_chan  (grant_chan)
  );

  // Only the granted channel sees ready
  assign b_ready = grant_valid && (grant_chan == TX_CHAN_B);
  assign r_ready = grant_valid && (grant_chan == TX_CHAN_R);

  //////////////////////////////
  // Packing
  //////////////////////////////

  // Payload in the low bits, push bit right above it, spare bits zero
  always_comb
  begin
    packet = '0;
    if (grant_valid)
    begin
      if (grant_chan == TX_CHAN_R)
      begin
        packet[0 +: `R_W] = r_data;
        packet[`R_W]      = 1'b1;
      end
      else
      begin
        packet[0 +: `B_W] = b_data;
        packet[`B_W]      = 1'b1;
      end
    end
  end

  // Idle word goes out tagged as B with push bit clear
  always_comb
  begin
    if (grant_valid)
    begin
      chan = grant_chan;
    end
    else
    begin
      chan = TX_CHAN_B;
    end
  end

endmodule

// ==== verilog/tx_rr_arbiter.sv ====
// Two-way round-robin arbiter between write-response and read-data transmit beats
module tx_rr_arbiter (
  input  logic                 clk_rd,
  input  logic                 rst_rd_n,
  input  logic                 b_req,
  input  logic                 r_req,
  output logic                 grant_valid,
  output concat_pkg::tx_chan_e grant_chan
);

  import concat_pkg::*;

  // Channel that won the most recent grant
  tx_chan_e last_chan;

  assign grant_valid = b_req | r_req;

  // Lone requester wins, a tie goes to the channel not served last
  always_comb
  begin
    if (b_req && r_req)
    begin
      grant_chan = (last_chan == TX_CHAN_R) ? TX_CHAN_B : TX_CHAN_R;
    end
    else if (r_req)
    begin
      grant_chan = TX_CHAN_R;
    end
    else
    begin
      grant_chan = TX_CHAN_B;
    end
  end

  // Starts at R so that B takes the first tie
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      last_chan <= TX_CHAN_R;
    end
    else if (grant_valid)
    begin
      last_chan <= grant_chan;
    end
  end

endmodule
